// File: src.f
Stark_pkg.sv
Stark_decode_alu.sv
Stark_decode_unit.sv
Stark_prefix_fsm.sv
Stark_prefix_counter.sv
Stark_decode_buffer.sv
Stark_decoder.sv
Stark_decoder_checker.sv
Stark_decoder_tb.sv

// File: run.sh
#!/bin/sh
# Build the decoder testbench with Verilator, run it and judge the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f src.f \
	--top-module Stark_decoder_tb -o simv \
	&& ./obj_dir/simv > sim.log 2>&1
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: Stark_decoder_tb.sv
// Table-driven testbench for the decoder classification and prefix stage
// with clock, reset, stimulus loop, output monitor and compare tasks
`timescale 1ns/10ps
`default_nettype none

module Stark_decoder_tb;
	import Stark_pkg::*;

	localparam int ClkPeriod = 20;
	localparam int InDelay = 2;
	// The output trails its strobe by exactly one cycle so a wait sees one idle sample at most
	localparam int WaitLimit = 1;
	localparam int DrainLimit = 8;

	// Unit bits in the order alu, fpu, mem, branch from bit 0 up
	localparam unitMask_t MaskAlu = 4'b0001;
	localparam unitMask_t MaskFpu = 4'b0010;
	localparam unitMask_t MaskMem = 4'b0100;
	localparam unitMask_t MaskBr = 4'b1000;

	// One table row, stimulus and the expected decoded word
	typedef struct packed {
		logic valid;
		instruction_t word;
		unitMask_t units;
		logic isPfx;
		pfxImm_t imm;
		pfxCount_t cnt;
		logic fault;
	} vector_t;

	logic clk;
	logic arstN;
	logic instrValid;
	instruction_t instr;
	logic decValid;
	logic pfxFault;
	decoded_t dec;

	vector_t vectors[$];
	// Rows driven into the DUT and still waiting for decValid
	vector_t pending[$];
	logic [31:0] lcgState = 32'h64c0;

	Stark_decoder dut_i (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.instr(instr),
		.decValid(decValid),
		.pfxFault(pfxFault),
		.dec(dec)
	);

	bind Stark_decoder Stark_decoder_checker checker_i (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.decValid(decValid),
		.pfxFault(pfxFault),
		.dec(dec)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// ============================================================
	// Helpers
	// ============================================================

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Word with random fields above the opcode
	function automatic logic [31:0] randWord(input logic [6:0] opc);
		logic [31:0] r;
		r = lcgNext();
		return {r[31:7], opc};
	endfunction

	// Float word with chosen func3, op4 and Rs2, random Rs1, Rd and size
	function automatic logic [31:0] makeWord(input logic [6:0] opc, input logic [2:0] f3,
		input logic [3:0] op4, input logic [4:0] rs2);
		logic [31:0] r;
		r = lcgNext();
		return {f3, op4, rs2, r[19:15], r[14:10], r[9:7], opc};
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
			failRun($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic checkUnits(input string name, input unitMask_t got, input unitMask_t exp);
		if (got !== exp)
			failRun($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic checkImm(input string name, input pfxImm_t got, input pfxImm_t exp);
		if (got !== exp)
			failRun($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic checkCount(input string name, input pfxCount_t got, input pfxCount_t exp);
		if (got !== exp)
			failRun($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic checkInstr(input string name, input instruction_t got,
		input instruction_t exp);
		if (got !== exp)
			failRun($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic addOp(input logic [31:0] w, input unitMask_t u, input pfxImm_t imm,
		input pfxCount_t cnt, input logic pfx, input logic fault);
		vector_t v;
		v.valid = 1'b1;
		v.word = w;
		v.units = u;
		v.isPfx = pfx;
		v.imm = imm;
		v.cnt = cnt;
		v.fault = fault;
		vectors.push_back(v);
	endtask

	// Idle cycle with junk on the instruction bus
	task automatic addGap();
		vector_t v;
		v = '0;
		v.word = randWord(OP_ADD);
		vectors.push_back(v);
	endtask

	// ============================================================
	// Stimulus table
	// ============================================================

	task automatic buildTable();
		logic [6:0] aluOps [16];
		logic [31:0] w1;
		logic [31:0] w2;
		logic [31:0] w4;
		aluOps = '{OP_CHK, OP_ADD, OP_SUBF, OP_CMP, OP_MUL, OP_DIV, OP_AND, OP_OR,
			OP_XOR, OP_ADB, OP_SHIFT, OP_CSR, OP_MOV, OP_LOADA, OP_NOP, OP_FENCE};
		for (int i = 0; i < 16; i++)
			addOp(randWord(aluOps[i]), MaskAlu, 50'd0, 2'd0, 1'b0, 1'b0);
		// Stack ops need memory too, DBcc needs the branch unit
		addOp(randWord(OP_PUSH), MaskAlu | MaskMem, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(randWord(OP_POP), MaskAlu | MaskMem, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(randWord(OP_DBCC0), MaskAlu | MaskBr, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(randWord(OP_DBCC1), MaskAlu | MaskBr, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(randWord(OP_LOAD), MaskMem, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(randWord(OP_STORE), MaskMem, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(randWord(OP_BCC), MaskBr, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(randWord(OP_JMP), MaskBr, 50'd0, 2'd0, 1'b0, 1'b0);
		addGap();
		addGap();
		// FABS and the G8 group go to the ALU, the rest of OP_FLT to the FPU
		addOp(makeWord(OP_FLT, 3'd1, 4'd0, 5'd1), MaskAlu, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(makeWord(OP_FLT, 3'd5, 4'd8, 5'd17), MaskAlu, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(makeWord(OP_FLT, 3'd1, 4'd0, 5'd2), MaskFpu, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(makeWord(OP_FLT, 3'd3, 4'd0, 5'd1), MaskFpu, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(makeWord(OP_FLT, 3'd0, 4'd0, 5'd0), MaskFpu, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(makeWord(OP_FLT, 3'd1, 4'd1, 5'd1), MaskFpu, 50'd0, 2'd0, 1'b0, 1'b0);
		addOp(makeWord(OP_FLT, 3'd6, 4'd1, 5'd9), MaskFpu, 50'd0, 2'd0, 1'b0, 1'b0);
		addGap();
		// One prefix lands in the upper half of the extension
		w1 = randWord(OP_PFX);
		addOp(w1, MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addOp(randWord(OP_ADD), MaskAlu, {w1[31:7], 25'd0}, 2'd1, 1'b0, 1'b0);
		// Two prefixes fill both halves
		w1 = randWord(OP_PFX);
		w2 = randWord(OP_PFX);
		addOp(w1, MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addOp(w2, MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addOp(randWord(OP_ADD), MaskAlu, {w1[31:7], w2[31:7]}, 2'd2, 1'b0, 1'b0);
		// A collected payload survives idle cycles
		w1 = randWord(OP_PFX);
		addOp(w1, MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addGap();
		addGap();
		addOp(randWord(OP_LOAD), MaskMem, {w1[31:7], 25'd0}, 2'd1, 1'b0, 1'b0);
		// Third prefix faults and drops everything collected
		addOp(randWord(OP_PFX), MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addOp(randWord(OP_PFX), MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addOp(randWord(OP_PFX), MaskAlu, 50'd0, 2'd0, 1'b1, 1'b1);
		addOp(randWord(OP_ADD), MaskAlu, 50'd0, 2'd0, 1'b0, 1'b0);
		// After a fault the next prefix starts a fresh run
		addOp(randWord(OP_PFX), MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addOp(randWord(OP_PFX), MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addOp(randWord(OP_PFX), MaskAlu, 50'd0, 2'd0, 1'b1, 1'b1);
		w4 = randWord(OP_PFX);
		addOp(w4, MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addOp(randWord(OP_STORE), MaskMem, {w4[31:7], 25'd0}, 2'd1, 1'b0, 1'b0);
		addGap();
		w1 = randWord(OP_PFX);
		w2 = randWord(OP_PFX);
		addOp(w1, MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addGap();
		addOp(w2, MaskAlu, 50'd0, 2'd0, 1'b1, 1'b0);
		addOp(randWord(OP_DBCC0), MaskAlu | MaskBr, {w1[31:7], w2[31:7]}, 2'd2, 1'b0,
			1'b0);
		addGap();
	endtask

	task automatic applyVector(input vector_t v);
		@(posedge clk);
		#InDelay;
		instrValid = v.valid;
		instr = v.word;
		if (v.valid)
			pending.push_back(v);
	endtask

	// ============================================================
	// Output monitor, sampling at the falling edge
	// ============================================================

	initial
	begin : monitor
		vector_t exp;
		int waitCycles;
		waitCycles = 0;
		forever
		begin
			@(negedge clk);
			if (arstN && decValid)
			begin
				if (pending.size() == 0)
					failRun("decValid pulsed with no instruction outstanding");
				else
				begin
					exp = pending.pop_front();
					waitCycles = 0;
					checkInstr("dec.instr", dec.instr, exp.word);
					checkUnits("dec.units", dec.units, exp.units);
					checkBit("dec.isPrefix", dec.isPrefix, exp.isPfx);
					checkImm("dec.pfxImm", dec.pfxImm, exp.imm);
					checkCount("dec.pfxCount", dec.pfxCount, exp.cnt);
					checkBit("pfxFault", pfxFault, exp.fault);
				end
			end
			else if (arstN)
			begin
				// A fault only ever rides along with an output word
				checkBit("pfxFault", pfxFault, 1'b0);
				if (pending.size() != 0)
				begin
					waitCycles++;
					if (waitCycles > WaitLimit)
						failRun("timeout while waiting for decValid");
				end
			end
		end
	end

	initial
	begin
		int drainCycles;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		buildTable();
		repeat (2) @(posedge clk);
		#InDelay;
		arstN = 1'b1;
		@(negedge clk);
		checkBit("decValid", decValid, 1'b0);
		checkBit("pfxFault", pfxFault, 1'b0);
		for (int i = 0; i < vectors.size(); i++)
			applyVector(vectors[i]);
		@(posedge clk);
		#InDelay;
		instrValid = 1'b0;
		drainCycles = 0;
		while (pending.size() != 0 && drainCycles < DrainLimit)
		begin
			@(posedge clk);
			drainCycles++;
		end
		repeat (2) @(posedge clk);
		if (pending.size() == 0)
		begin
			$display("all tests passed");
			$finish;
		end
		else
			failRun("instructions were left without decValid at the end of the run");
	end

endmodule

`default_nettype wire

// File: Stark_decoder_checker.sv
// Concurrent checks on the decoder outputs, bound into the top level
`timescale 1ns/10ps
`default_nettype none

module Stark_decoder_checker (
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input logic decValid,
	input logic pfxFault,
	input Stark_pkg::decoded_t dec
);
	import Stark_pkg::*;

	// ============================================================
	// Output timing
	// ============================================================

	// Every strobe gives exactly one output pulse one edge later
	validAfterStrobe: assert property (@(posedge clk) disable iff (!arstN)
		instrValid |=> decValid)
		else $error("decValid missing one cycle after instrValid");

	noValidWithoutStrobe: assert property (@(posedge clk) disable iff (!arstN)
		!instrValid |=> !decValid)
		else $error("decValid without a preceding instrValid");

	// ============================================================
	// Prefix rules
	// ============================================================

	// The faulting prefix carries no extension of its own
	faultHasNoCount: assert property (@(posedge clk) disable iff (!arstN)
		pfxFault |-> dec.pfxCount == '0)
		else $error("pfxFault together with a nonzero pfxCount");

	countWithinLimit: assert property (@(posedge clk) disable iff (!arstN)
		decValid |-> dec.pfxCount <= MaxPrefix)
		else $error("dec.pfxCount above the prefix limit");

endmodule

`default_nettype wire

// File: Stark_decoder.sv
// Top of the classification and prefix stage
`timescale 1ns/10ps
`default_nettype none

module Stark_decoder (
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input Stark_pkg::instruction_t instr,
	output logic decValid,
	output logic pfxFault,
	output Stark_pkg::decoded_t dec
);
	import Stark_pkg::*;

	// Unit flags from the two classifiers
	logic alu;
	logic fpu;
	logic mem;
	logic branch;
	logic isPrefix;

	// Prefix run bookkeeping
	pfxCount_t count;
	logic cntInc;
	logic cntClear;
	logic pfxStore;
	logic pfxClear;

	Stark_decode_alu decodeAlu (
		.instr(instr),
		.alu(alu)
	);

	Stark_decode_unit decodeUnit (
		.instr(instr),
		.fpu(fpu),
		.mem(mem),
		.branch(branch),
		.isPrefix(isPrefix)
	);

	Stark_prefix_fsm prefixFsm (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.isPrefix(isPrefix),
		.count(count),
		.cntInc(cntInc),
		.cntClear(cntClear),
		.pfxStore(pfxStore),
		.pfxClear(pfxClear),
		.pfxFault(pfxFault)
	);

	Stark_prefix_counter prefixCounter (
		.clk(clk),
		.arstN(arstN),
		.cntInc(cntInc),
		.cntClear(cntClear),
		.count(count)
	);

	// Output stage, one cycle behind the strobe
	Stark_decode_buffer decodeBuffer (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.alu(alu),
		.fpu(fpu),
		.mem(mem),
		.branch(branch),
		.isPrefix(isPrefix),
		.pfxStore(pfxStore),
		.pfxClear(pfxClear),
		.instr(instr),
		.count(count),
		.decValid(decValid),
		.dec(dec)
	);

endmodule

`default_nettype wire

// File: Stark_decode_buffer.sv
// Prefix payload store and the registered decoded output word
`timescale 1ns/10ps
`default_nettype none

module Stark_decode_buffer (
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input logic alu,
	input logic fpu,
	input logic mem,
	input logic branch,
	input logic isPrefix,
	input logic pfxStore,
	input logic pfxClear,
	input Stark_pkg::instruction_t instr,
	input Stark_pkg::pfxCount_t count,
	output logic decValid,
	output Stark_pkg::decoded_t dec
);
	import Stark_pkg::*;

	pfxPayload_t payload;
	pfxImm_t pfxImm;
	unitMask_t units;

	// Everything above the opcode is prefix payload
	assign payload = instr[31:7];

	always_comb
	begin
		units = '0;
		units[UnitAlu] = alu;
		units[UnitFpu] = fpu;
		units[UnitMem] = mem;
		units[UnitBranch] = branch;
	end

	// ============================================================
	// Payload store
	// ============================================================

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			pfxImm <= '0;
		else if (pfxClear)
			pfxImm <= '0;
		else if (pfxStore)
		begin
			// First prefix fills the upper half, second the lower
			if (count == 2'd0)
				pfxImm[49:25] <= payload;
			else
				pfxImm[24:0] <= payload;
		end
	end

	// ============================================================
	// Output register
	// ============================================================

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			decValid <= 1'b0;
		else
			decValid <= instrValid;
	end

	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			dec.instr <= instr;
			dec.units <= units;
			dec.isPrefix <= isPrefix;
			// The consumer sees the payload as it stood before this edge
			dec.pfxImm <= isPrefix ? '0 : pfxImm;
			dec.pfxCount <= isPrefix ? '0 : count;
		end
	end

endmodule

`default_nettype wire

// File: Stark_prefix_counter.sv
// Counter of consecutive prefixes in the current run
`timescale 1ns/10ps
`default_nettype none

module Stark_prefix_counter (
	input logic clk,
	input logic arstN,
	input logic cntInc,
	input logic cntClear,
	output Stark_pkg::pfxCount_t count
);
	import Stark_pkg::*;

	// The FSM never increments past MaxPrefix, so no saturation here
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			count <= '0;
		// Ending a run wins over any increment
		else if (cntClear)
			count <= '0;
		else if (cntInc)
			count <= count + pfxCount_t'(1);
	end

endmodule

`default_nettype wire

// File: Stark_prefix_fsm.sv
// State machine for prefix runs, steering the counter and payload store
`timescale 1ns/10ps
`default_nettype none

module Stark_prefix_fsm (
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input logic isPrefix,
	input Stark_pkg::pfxCount_t count,
	output logic cntInc,
	output logic cntClear,
	output logic pfxStore,
	output logic pfxClear,
	output logic pfxFault
);
	import Stark_pkg::*;

	pfxState_t state;
	pfxState_t stateNext;
	logic atLimit;
	logic roomLeft;
	logic acceptPfx;
	logic thirdPfx;
	logic takeNonPfx;

	// A run is full once the counter reaches the limit
	assign atLimit = (count == MaxPrefix);
	// The state agrees with the count, PfxTwo means no room either
	assign roomLeft = !atLimit && (state != PfxTwo);

	assign acceptPfx = instrValid && isPrefix && roomLeft;
	// One prefix too many
	assign thirdPfx = instrValid && isPrefix && !roomLeft;
	assign takeNonPfx = instrValid && !isPrefix;

	// A legal prefix extends the run
	assign cntInc = acceptPfx;
	assign pfxStore = acceptPfx;

	// The run ends on its consumer or on a fault
	assign cntClear = thirdPfx || takeNonPfx;
	assign pfxClear = thirdPfx || takeNonPfx;

	always_comb
	begin
		stateNext = state;
		if (acceptPfx)
		begin
			case (state)
			PfxIdle:
				stateNext = PfxOne;
			PfxOne:
				stateNext = PfxTwo;
			default:
				stateNext = PfxIdle;
			endcase
		end
		else if (thirdPfx || takeNonPfx)
			stateNext = PfxIdle;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= PfxIdle;
			pfxFault <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			// Fault shows up with the offending prefix's output word
			pfxFault <= thirdPfx;
		end
	end

endmodule

`default_nettype wire

// File: Stark_decode_unit.sv
// FPU, memory and branch classifiers and prefix recognition
`timescale 1ns/10ps
`default_nettype none

module Stark_decode_unit (
	input Stark_pkg::instruction_t instr,
	output logic fpu,
	output logic mem,
	output logic branch,
	output logic isPrefix
);
	import Stark_pkg::*;

	logic isFlt;
	logic isFabs;
	logic fltOnAlu;

	// ============================================================
	// Float split
	// ============================================================

	assign isFlt = (instr.opcode == OP_FLT);

	// Same FABS pattern the ALU classifier looks for
	assign isFabs = (instr.op4 == FOP4_FADD) && (instr.func3 == 3'b001)
		&& (instr.Rs2 == 5'd1);

	// These float ops are stolen by the ALU when PERFORMANCE is on
	assign fltOnAlu = PERFORMANCE && (isFabs || (instr.op4 == FOP4_G8));

	// Everything else under OP_FLT needs the real FPU
	assign fpu = isFlt && !fltOnAlu;

	// ============================================================
	// Memory, branch and prefix
	// ============================================================

	always_comb
	begin
		case (instr.opcode)
		OP_LOAD, OP_STORE:
			mem = 1'b1;
		// Stack ops access memory in addition to the ALU
		OP_PUSH, OP_POP:
			mem = 1'b1;
		default:
			mem = 1'b0;
		endcase
	end

	always_comb
	begin
		case (instr.opcode)
		OP_BCC, OP_JMP:
			branch = 1'b1;
		default:
			// DBcc also needs the branch unit for its target
			branch = fnIsDBcc(instr);
		endcase
	end

	assign isPrefix = (instr.opcode == OP_PFX);

endmodule

`default_nettype wire

// File: Stark_decode_alu.sv
// ALU-class classifier for one instruction word
`timescale 1ns/10ps
`default_nettype none

module Stark_decode_alu (
	input Stark_pkg::instruction_t instr,
	output logic alu
);
	import Stark_pkg::*;

	always_comb
	begin
		case (instr.opcode)
		OP_FLT:
			// Only the cheap float cases go to the ALU
			case (instr.op4)
			FOP4_FADD:
				// FABS is FADD with func3 of 1 and Rs2 of 1
				if (instr.func3 == 3'b001 && instr.Rs2 == 5'd1)
					alu = PERFORMANCE;
				else
					alu = 1'b0;
			FOP4_G8:
				alu = PERFORMANCE;
			default:
				alu = 1'b0;
			endcase
		// Integer arithmetic and logic
		OP_CHK, OP_ADD, OP_SUBF, OP_CMP, OP_MUL, OP_DIV:
			alu = 1'b1;
		OP_AND, OP_OR, OP_XOR, OP_ADB, OP_SHIFT:
			alu = 1'b1;
		// Moves, CSR access and address generation
		OP_CSR, OP_MOV, OP_LOADA:
			alu = 1'b1;
		// Stack ops update the pointer through the ALU as well
		OP_PFX, OP_NOP, OP_PUSH, OP_POP:
			alu = 1'b1;
		OP_FENCE:
			alu = 1'b1;
		default:
			// DBcc decrements its counter in the ALU
			alu = fnIsDBcc(instr);
		endcase
	end

endmodule

`default_nettype wire

// File: Stark_pkg.sv
// Shared opcodes, instruction and decode structs, width types, prefix FSM states
// and the DBcc helper for the decoder classification stage
`default_nettype none

package Stark_pkg;

	// ============================================================
	// Widths that carry a meaning
	// ============================================================

	// One prefix payload is instruction bits 31 to 7
	typedef logic [24:0] pfxPayload_t;
	// Two payloads side by side, first prefix in the upper half
	typedef logic [49:0] pfxImm_t;
	// Number of prefixes applied to an instruction
	typedef logic [1:0] pfxCount_t;
	// One bit per functional unit, indexed by the Unit* constants below
	typedef logic [3:0] unitMask_t;

	// Turns on ALU handling of FABS and the FOP4_G8 group
	localparam logic PERFORMANCE = 1'b1;
	// Longest legal run of consecutive prefixes
	localparam pfxCount_t MaxPrefix = 2'd2;

	// Bit positions inside unitMask_t
	localparam int UnitAlu = 0;
	localparam int UnitFpu = 1;
	localparam int UnitMem = 2;
	localparam int UnitBranch = 3;

	// ============================================================
	// Encodings
	// ============================================================

	typedef enum logic [6:0] {
		OP_NOP    = 7'd0,
		OP_ADD    = 7'd4,
		OP_SUBF   = 7'd5,
		OP_CMP    = 7'd6,
		OP_MUL    = 7'd7,
		OP_DIV    = 7'd8,
		OP_AND    = 7'd9,
		OP_OR     = 7'd10,
		OP_XOR    = 7'd11,
		OP_ADB    = 7'd12,
		OP_SHIFT  = 7'd13,
		OP_CSR    = 7'd14,
		OP_MOV    = 7'd15,
		OP_LOADA  = 7'd16,
		OP_CHK    = 7'd17,
		OP_FLT    = 7'd18,
		OP_PFX    = 7'd32,
		OP_PUSH   = 7'd34,
		OP_POP    = 7'd35,
		OP_FENCE  = 7'd36,
		OP_LOAD   = 7'd40,
		OP_STORE  = 7'd41,
		OP_BCC    = 7'd48,
		OP_JMP    = 7'd49,
		OP_DBCC0  = 7'd50,
		OP_DBCC1  = 7'd51
	} opcode_t;

	// Float sub-operation held in op4 of an OP_FLT word
	typedef enum logic [3:0] {
		FOP4_FADD = 4'd0,
		FOP4_FMUL = 4'd1,
		FOP4_G8   = 4'd8
	} fop4_t;

	// Field layout of one 32-bit instruction word, opcode at the low end
	typedef struct packed {
		logic [2:0] func3;
		fop4_t op4;
		logic [4:0] Rs2;
		logic [4:0] Rs1;
		logic [4:0] Rd;
		// Operand size bits, carried along but not classified here
		logic [2:0] sz;
		opcode_t opcode;
	} instruction_t;

	// Word handed on to issue, 89 bits in all
	typedef struct packed {
		instruction_t instr;
		unitMask_t units;
		logic isPrefix;
		pfxImm_t pfxImm;
		pfxCount_t pfxCount;
	} decoded_t;

	// Position within a run of prefixes
	typedef enum logic [1:0] {
		PfxIdle = 2'd0,
		PfxOne  = 2'd1,
		PfxTwo  = 2'd2
	} pfxState_t;

	// Both decrement-and-branch encodings count as DBcc
	function automatic logic fnIsDBcc(input instruction_t ir);
		return (ir.opcode == OP_DBCC0) || (ir.opcode == OP_DBCC1);
	endfunction

endpackage

`default_nettype wire
